// File: common/core_pkg.sv
package core_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [63:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes of the integer ALU groups
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        logic     wen;
        xlen_t    opa;
        xlen_t    opb;
        xlen_t    rs1_val;
        xlen_t    imm;
        alu_op_e  alu_op;
        br_op_e   br_op;
    } dec_pkt_t;

    // also used as the commit record
    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        logic     wen;
        xlen_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

endpackage

// File: ifu/ifu.sv
`timescale 1ns/1ps

module ifu #(
    parameter core_pkg::addr_t RST_PC = 64'h0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ifu_arready,
    output logic                 ifu_arvalid,
    output core_pkg::addr_t      ifu_araddr,
    input  logic                 ifu_rvalid,
    output logic                 ifu_rready,
    input  core_pkg::xlen_t      ifu_rdata,
    input  core_pkg::redirect_t  redirect,
    output logic                 fetch_valid,
    output core_pkg::fetch_pkt_t fetch_pkt,
    input  logic                 fetch_ready
);
    import core_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} fetch_state_e;

    fetch_state_e state;
    addr_t        pc;
    logic         stale;
    logic         resp_fire;

    assign ifu_arvalid = (state == S_ADDR);
    // response waits until the packet register can take it
    assign ifu_rready  = !fetch_valid || fetch_ready;
    assign resp_fire   = (state == S_DATA) && ifu_rvalid && ifu_rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            pc    <= RST_PC;
            stale <= 1'b0;
        end else begin
            if (redirect.taken) begin
                pc <= redirect.target;
            end
            case (state)
                S_IDLE: begin
                    if (!redirect.taken) begin
                        state <= S_ADDR;
                        pc    <= pc + 64'd4;
                    end
                end
                S_ADDR: begin
                    // address already on the bus, its data is now unwanted
                    if (redirect.taken) begin
                        stale <= 1'b1;
                    end
                    if (ifu_arready) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (resp_fire) begin
                        state <= S_IDLE;
                        stale <= 1'b0;
                    end else if (redirect.taken) begin
                        stale <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            ifu_araddr <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else if (redirect.taken) begin
            fetch_valid <= 1'b0;
        end else if (resp_fire && !stale) begin
            fetch_valid <= 1'b1;
        end else if (fetch_ready) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            fetch_pkt.pc   <= ifu_araddr;
            fetch_pkt.inst <= ifu_rdata[31:0];
        end
    end

    a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
        ifu_arvalid && !ifu_arready |=> ifu_arvalid && $stable(ifu_araddr));

endmodule

// File: idu/idu.sv
`timescale 1ns/1ps

module idu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_valid,
    input  core_pkg::fetch_pkt_t fetch_pkt,
    output logic                 fetch_ready,
    output core_pkg::reg_idx_t   rs1,
    output core_pkg::reg_idx_t   rs2,
    input  core_pkg::xlen_t      rs1_val,
    input  core_pkg::xlen_t      rs2_val,
    input  logic                 ex_valid,
    input  core_pkg::wb_pkt_t    ex_pkt,
    input  core_pkg::redirect_t  redirect,
    output logic                 dec_valid,
    output core_pkg::dec_pkt_t   dec_pkt
);
    import core_pkg::*;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    inst_t       inst;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    xlen_t       imm_i;
    xlen_t       imm_u;
    xlen_t       imm_b;
    xlen_t       imm_j;
    dec_pkt_t    d;
    logic        writes;
    logic        use_rs1;
    logic        use_rs2;
    logic        stall;

    function automatic alu_op_e alu_dec(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // pending write to r by a valid stage packet
    function automatic logic raw(input reg_idx_t r, input logic v, input logic wen,
                                 input reg_idx_t dst);
        return v && wen && (dst == r);
    endfunction

    assign inst   = fetch_pkt.inst;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        d         = '0;
        d.pc      = fetch_pkt.pc;
        d.rd      = rd;
        d.rs1_val = rs1_val;
        d.alu_op  = ALU_ADD;
        d.br_op   = BR_NONE;
        writes    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            OP_LUI: begin
                writes = 1'b1;
                d.opb  = imm_u;
            end
            OP_AUIPC: begin
                writes = 1'b1;
                d.opa  = fetch_pkt.pc;
                d.opb  = imm_u;
            end
            OP_JAL, OP_JALR: begin
                // link value pc+4 goes through the adder
                writes  = 1'b1;
                use_rs1 = (opcode == OP_JALR);
                d.opa   = fetch_pkt.pc;
                d.opb   = 64'd4;
                d.imm   = (opcode == OP_JALR) ? imm_i : imm_j;
                d.br_op = (opcode == OP_JALR) ? BR_JALR : BR_JAL;
            end
            OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                d.opa   = rs1_val;
                d.opb   = rs2_val;
                d.imm   = imm_b;
                case (funct3)
                    3'b000:  d.br_op = BR_BEQ;
                    3'b001:  d.br_op = BR_BNE;
                    3'b100:  d.br_op = BR_BLT;
                    3'b101:  d.br_op = BR_BGE;
                    3'b110:  d.br_op = BR_BLTU;
                    3'b111:  d.br_op = BR_BGEU;
                    default: d.br_op = BR_NONE;
                endcase
            end
            OP_IMM: begin
                writes   = 1'b1;
                use_rs1  = 1'b1;
                d.opa    = rs1_val;
                d.opb    = imm_i;
                d.alu_op = alu_dec(funct3, funct7[5] && (funct3 == 3'b101));
            end
            OP_REG: begin
                writes   = 1'b1;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                d.opa    = rs1_val;
                d.opb    = rs2_val;
                d.alu_op = alu_dec(funct3, funct7[5]);
            end
            default: ;
        endcase
        d.wen = writes && (rd != '0);
    end

    assign stall = (use_rs1 && (rs1 != '0) &&
                    (raw(rs1, dec_valid, dec_pkt.wen, dec_pkt.rd) ||
                     raw(rs1, ex_valid, ex_pkt.wen, ex_pkt.rd))) ||
                   (use_rs2 && (rs2 != '0) &&
                    (raw(rs2, dec_valid, dec_pkt.wen, dec_pkt.rd) ||
                     raw(rs2, ex_valid, ex_pkt.wen, ex_pkt.rd)));

    assign fetch_ready = !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (redirect.taken) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= fetch_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            dec_pkt <= d;
        end
    end

endmodule

// File: exu/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic                clk,
    input  logic                rst,
    input  logic                dec_valid,
    input  core_pkg::dec_pkt_t  dec_pkt,
    output core_pkg::redirect_t redirect,
    output logic                ex_valid,
    output core_pkg::wb_pkt_t   ex_pkt
);
    import core_pkg::*;

    xlen_t      a;
    xlen_t      b;
    logic [5:0] shamt;
    xlen_t      alu_res;
    xlen_t      jalr_sum;
    logic       cond;

    assign a     = dec_pkt.opa;
    assign b     = dec_pkt.opb;
    assign shamt = b[5:0];

    always_comb begin
        case (dec_pkt.alu_op)
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_SLL:  alu_res = a << shamt;
            ALU_SRL:  alu_res = a >> shamt;
            ALU_SRA:  alu_res = $signed(a) >>> shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, a < b};
            default:  alu_res = a + b;
        endcase
    end

    // branches compare rs1/rs2 held in the operands
    always_comb begin
        case (dec_pkt.br_op)
            BR_BEQ:          cond = (a == b);
            BR_BNE:          cond = (a != b);
            BR_BLT:          cond = $signed(a) < $signed(b);
            BR_BGE:          cond = $signed(a) >= $signed(b);
            BR_BLTU:         cond = a < b;
            BR_BGEU:         cond = a >= b;
            BR_JAL, BR_JALR: cond = 1'b1;
            default:         cond = 1'b0;
        endcase
    end

    assign jalr_sum = dec_pkt.rs1_val + dec_pkt.imm;

    assign redirect.taken  = dec_valid && cond;
    assign redirect.target = (dec_pkt.br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                         : dec_pkt.pc + dec_pkt.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_pkt.pc   <= dec_pkt.pc;
            ex_pkt.rd   <= dec_pkt.rd;
            ex_pkt.wen  <= dec_pkt.wen;
            ex_pkt.data <= alu_res;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (rst)
        redirect.taken |-> redirect.target[1:0] == 2'b00);

endmodule

// File: wbu/wbu.sv
`timescale 1ns/1ps

module wbu (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::xlen_t    rs1_val,
    output core_pkg::xlen_t    rs2_val,
    input  logic               ex_valid,
    input  core_pkg::wb_pkt_t  ex_pkt,
    output logic               commit_valid,
    output core_pkg::wb_pkt_t  commit
);
    import core_pkg::*;

    // x0 has no storage
    xlen_t regs [1:31];

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_pkt.wen && (ex_pkt.rd != '0)) begin
            regs[ex_pkt.rd] <= ex_pkt.data;
        end
    end

    // retire record leaves the core in program order
    assign commit_valid = ex_valid;
    assign commit       = ex_pkt;

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        commit_valid && commit.wen |-> commit.rd != '0);

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter core_pkg::addr_t RST_PC = 64'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ifu_arready,
    output logic              ifu_arvalid,
    output core_pkg::addr_t   ifu_araddr,
    input  logic              ifu_rvalid,
    output logic              ifu_rready,
    input  core_pkg::xlen_t   ifu_rdata,
    output logic              commit_valid,
    output core_pkg::wb_pkt_t commit
);
    import core_pkg::*;

    redirect_t  redirect;
    logic       fetch_valid;
    logic       fetch_ready;
    fetch_pkt_t fetch_pkt;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    logic       dec_valid;
    dec_pkt_t   dec_pkt;
    logic       ex_valid;
    wb_pkt_t    ex_pkt;

    ifu #(.RST_PC(RST_PC)) u_ifu (
        .clk         (clk),
        .rst         (rst),
        .ifu_arready (ifu_arready),
        .ifu_arvalid (ifu_arvalid),
        .ifu_araddr  (ifu_araddr),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_rdata   (ifu_rdata),
        .redirect    (redirect),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .fetch_ready (fetch_ready)
    );

    idu u_idu (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .fetch_ready (fetch_ready),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .ex_valid    (ex_valid),
        .ex_pkt      (ex_pkt),
        .redirect    (redirect),
        .dec_valid   (dec_valid),
        .dec_pkt     (dec_pkt)
    );

    exu u_exu (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_pkt   (dec_pkt),
        .redirect  (redirect),
        .ex_valid  (ex_valid),
        .ex_pkt    (ex_pkt)
    );

    wbu u_wbu (
        .clk          (clk),
        .rst          (rst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .ex_valid     (ex_valid),
        .ex_pkt       (ex_pkt),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter time PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    localparam addr_t RST_PC = 64'h1000;
    localparam int NT = 3;
    localparam int NW = 24;

    logic    clk;
    logic    rst;
    logic    ifu_arready;
    logic    ifu_arvalid;
    addr_t   ifu_araddr;
    logic    ifu_rvalid;
    logic    ifu_rready;
    xlen_t   ifu_rdata;
    logic    commit_valid;
    wb_pkt_t commit;

    // program and expected-commit tables
    string    names [NT];
    inst_t    prog [NT][NW];
    int       n_inst [NT];
    addr_t    e_pc [NT][NW];
    reg_idx_t e_rd [NT][NW];
    logic     e_wen [NT][NW];
    xlen_t    e_data [NT][NW];
    int       n_exp [NT];

    int         cur;
    int         mismatches;
    int         failures;
    logic       first_ar;
    logic       pending;
    logic [1:0] adelay;
    logic [1:0] rdelay;
    addr_t      raddr;

    tb_clock #(.PERIOD(100)) clk_gen (.clk(clk));

    core_top #(.RST_PC(RST_PC)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .ifu_arready  (ifu_arready),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_araddr   (ifu_araddr),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rready   (ifu_rready),
        .ifu_rdata    (ifu_rdata),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    function automatic inst_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic inst_t u_type(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic inst_t j_type(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // opcode 0 is outside the kept set, so stray fetches retire without a write
    function automatic inst_t fill_word(addr_t a);
        return (a[63:32] ^ a[31:0]) & 32'hffff_ff80;
    endfunction

    function automatic inst_t word_at(addr_t a);
        addr_t off;
        int    idx;
        off = a - RST_PC;
        idx = int'(off[6:2]);
        if (off < 64'd96 && idx < n_inst[cur]) begin
            return prog[cur][idx];
        end
        return fill_word(a);
    endfunction

    task automatic add_inst(int t, inst_t w);
        prog[t][n_inst[t]] = w;
        n_inst[t] = n_inst[t] + 1;
    endtask

    task automatic add_commit(int t, addr_t pc, reg_idx_t rd, logic wen, xlen_t data);
        e_pc[t][n_exp[t]]   = pc;
        e_rd[t][n_exp[t]]   = rd;
        e_wen[t][n_exp[t]]  = wen;
        e_data[t][n_exp[t]] = data;
        n_exp[t] = n_exp[t] + 1;
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic check_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic check_data(string name, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic wait_commit(output logic ok);
        ok = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            if (commit_valid) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic build_tables();
        names[0] = "alu";
        add_inst(0, i_type(-12'sd5, 0, 3'b000, 1, OP_IMM));
        add_inst(0, i_type(12'd3, 0, 3'b000, 2, OP_IMM));
        add_inst(0, r_type(7'h20, 2, 1, 3'b101, 3));
        add_inst(0, r_type(7'h00, 2, 1, 3'b101, 4));
        add_inst(0, r_type(7'h00, 2, 1, 3'b010, 5));
        add_inst(0, r_type(7'h00, 2, 1, 3'b011, 6));
        add_inst(0, r_type(7'h20, 1, 2, 3'b000, 7));
        add_inst(0, i_type(12'h00f, 1, 3'b100, 8, OP_IMM));
        add_inst(0, r_type(7'h00, 2, 2, 3'b001, 9));
        add_inst(0, r_type(7'h00, 2, 1, 3'b110, 10));
        add_inst(0, r_type(7'h00, 2, 1, 3'b111, 11));
        add_inst(0, i_type(12'd62, 2, 3'b001, 12, OP_IMM));
        add_inst(0, i_type(12'd1, 1, 3'b000, 0, OP_IMM));
        add_inst(0, u_type(20'h12345, 13, 7'b0110111));
        add_inst(0, u_type(20'h00001, 14, 7'b0010111));
        add_inst(0, i_type(12'h401, 1, 3'b101, 15, OP_IMM));
        add_inst(0, i_type(-12'sd4, 1, 3'b010, 16, OP_IMM));
        add_inst(0, i_type(-12'sd1, 2, 3'b011, 17, OP_IMM));
        add_inst(0, r_type(7'h00, 2, 1, 3'b100, 18));
        add_inst(0, i_type(12'h0f0, 1, 3'b111, 19, OP_IMM));
        add_inst(0, i_type(-12'sd8, 2, 3'b110, 20, OP_IMM));
        add_inst(0, i_type(12'd60, 1, 3'b101, 21, OP_IMM));
        add_commit(0, 64'h1000, 1, 1'b1, 64'hffff_ffff_ffff_fffb);
        add_commit(0, 64'h1004, 2, 1'b1, 64'd3);
        add_commit(0, 64'h1008, 3, 1'b1, 64'hffff_ffff_ffff_ffff);
        add_commit(0, 64'h100c, 4, 1'b1, 64'h1fff_ffff_ffff_ffff);
        add_commit(0, 64'h1010, 5, 1'b1, 64'd1);
        add_commit(0, 64'h1014, 6, 1'b1, 64'd0);
        add_commit(0, 64'h1018, 7, 1'b1, 64'd8);
        add_commit(0, 64'h101c, 8, 1'b1, 64'hffff_ffff_ffff_fff4);
        add_commit(0, 64'h1020, 9, 1'b1, 64'd24);
        add_commit(0, 64'h1024, 10, 1'b1, 64'hffff_ffff_ffff_fffb);
        add_commit(0, 64'h1028, 11, 1'b1, 64'd3);
        add_commit(0, 64'h102c, 12, 1'b1, 64'hc000_0000_0000_0000);
        add_commit(0, 64'h1030, 0, 1'b0, 64'd0);
        add_commit(0, 64'h1034, 13, 1'b1, 64'h1234_5000);
        add_commit(0, 64'h1038, 14, 1'b1, 64'h2038);
        add_commit(0, 64'h103c, 15, 1'b1, 64'hffff_ffff_ffff_fffd);
        add_commit(0, 64'h1040, 16, 1'b1, 64'd1);
        add_commit(0, 64'h1044, 17, 1'b1, 64'd1);
        add_commit(0, 64'h1048, 18, 1'b1, 64'hffff_ffff_ffff_fff8);
        add_commit(0, 64'h104c, 19, 1'b1, 64'h0f0);
        add_commit(0, 64'h1050, 20, 1'b1, 64'hffff_ffff_ffff_fffb);
        add_commit(0, 64'h1054, 21, 1'b1, 64'hf);

        // taken branches skip the addi x3 slots
        names[1] = "branch";
        add_inst(1, i_type(12'd1, 0, 3'b000, 1, OP_IMM));
        add_inst(1, i_type(-12'sd1, 0, 3'b000, 2, OP_IMM));
        add_inst(1, b_type(13'd8, 2, 1, 3'b000));
        add_inst(1, b_type(13'd8, 2, 1, 3'b001));
        add_inst(1, i_type(12'd99, 0, 3'b000, 3, OP_IMM));
        add_inst(1, b_type(13'd8, 1, 2, 3'b100));
        add_inst(1, i_type(12'd98, 0, 3'b000, 3, OP_IMM));
        add_inst(1, b_type(13'd8, 1, 2, 3'b110));
        add_inst(1, b_type(13'd8, 2, 1, 3'b101));
        add_inst(1, i_type(12'd97, 0, 3'b000, 3, OP_IMM));
        add_inst(1, b_type(13'd8, 1, 2, 3'b111));
        add_inst(1, i_type(12'd96, 0, 3'b000, 3, OP_IMM));
        add_inst(1, b_type(13'd8, 1, 1, 3'b000));
        add_inst(1, i_type(12'd95, 0, 3'b000, 3, OP_IMM));
        add_inst(1, b_type(13'd8, 2, 1, 3'b110));
        add_inst(1, i_type(12'd94, 0, 3'b000, 3, OP_IMM));
        add_inst(1, i_type(12'd7, 0, 3'b000, 4, OP_IMM));
        add_commit(1, 64'h1000, 1, 1'b1, 64'd1);
        add_commit(1, 64'h1004, 2, 1'b1, 64'hffff_ffff_ffff_ffff);
        add_commit(1, 64'h1008, 0, 1'b0, 64'd0);
        add_commit(1, 64'h100c, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1014, 0, 1'b0, 64'd0);
        add_commit(1, 64'h101c, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1020, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1028, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1030, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1038, 0, 1'b0, 64'd0);
        add_commit(1, 64'h1040, 4, 1'b1, 64'd7);

        names[2] = "jump";
        add_inst(2, j_type(21'd12, 1));
        add_inst(2, i_type(12'd1, 0, 3'b000, 5, OP_IMM));
        add_inst(2, i_type(12'd2, 0, 3'b000, 5, OP_IMM));
        add_inst(2, u_type(20'h00001, 2, 7'b0110111));
        add_inst(2, i_type(12'd33, 2, 3'b000, 3, 7'b1100111));
        add_inst(2, i_type(12'd3, 0, 3'b000, 5, OP_IMM));
        add_inst(2, i_type(12'd4, 0, 3'b000, 5, OP_IMM));
        add_inst(2, i_type(12'd5, 0, 3'b000, 5, OP_IMM));
        add_inst(2, r_type(7'h00, 3, 1, 3'b000, 4));
        add_commit(2, 64'h1000, 1, 1'b1, 64'h1004);
        add_commit(2, 64'h100c, 2, 1'b1, 64'h1000);
        add_commit(2, 64'h1010, 3, 1'b1, 64'h1014);
        add_commit(2, 64'h1020, 4, 1'b1, 64'h2018);
    endtask

    // instruction memory with random arready/rvalid delays of 0 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            ifu_arready <= 1'b0;
            ifu_rvalid  <= 1'b0;
            pending     <= 1'b0;
            first_ar    <= 1'b1;
            adelay      <= 2'($urandom % 4);
        end else begin
            if (ifu_arvalid && ifu_arready) begin
                if (first_ar) begin
                    check_addr({names[cur], ".reset_pc"}, RST_PC, ifu_araddr);
                end
                first_ar    <= 1'b0;
                ifu_arready <= 1'b0;
                raddr       <= ifu_araddr;
                pending     <= 1'b1;
                rdelay      <= 2'($urandom % 4);
                adelay      <= 2'($urandom % 4);
            end else if (ifu_arvalid) begin
                if (adelay == 2'd0) begin
                    ifu_arready <= 1'b1;
                end else begin
                    adelay <= adelay - 2'd1;
                end
            end
            if (pending) begin
                if (ifu_rvalid && ifu_rready) begin
                    ifu_rvalid <= 1'b0;
                    pending    <= 1'b0;
                end else if (!ifu_rvalid) begin
                    if (rdelay == 2'd0) begin
                        ifu_rvalid <= 1'b1;
                        ifu_rdata  <= {32'h0, word_at(raddr)};
                    end else begin
                        rdelay <= rdelay - 2'd1;
                    end
                end
            end
        end
    end

    initial begin
        logic  ok;
        string tag;
        void'($urandom(1));
        rst         <= 1'b1;
        ifu_arready <= 1'b0;
        ifu_rvalid  <= 1'b0;
        ifu_rdata   <= '0;
        cur         = 0;
        mismatches  = 0;
        failures    = 0;
        n_inst      = '{default: 0};
        n_exp       = '{default: 0};
        build_tables();
        for (int t = 0; t < NT; t++) begin
            @(posedge clk);
            rst <= 1'b1;
            cur = t;
            // the DUT sees rst from the next edge on
            @(posedge clk);
            repeat (15) begin
                @(negedge clk);
                if (commit_valid) begin
                    $display("commit_valid went high during reset in %s", names[t]);
                    failures = failures + 1;
                end
            end
            @(posedge clk);
            rst <= 1'b0;
            for (int k = 0; k < n_exp[t]; k++) begin
                wait_commit(ok);
                if (!ok) begin
                    $display("timed out waiting for commit %0d of %s", k, names[t]);
                    failures = failures + 1;
                    break;
                end
                tag = $sformatf("%s[%0d]", names[t], k);
                check_addr({tag, ".pc"}, e_pc[t][k], commit.pc);
                check_flag({tag, ".wen"}, e_wen[t][k], commit.wen);
                if (e_wen[t][k]) begin
                    check_idx({tag, ".rd"}, e_rd[t][k], commit.rd);
                    check_data({tag, ".data"}, e_data[t][k], commit.data);
                end
            end
        end
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim.f
common/core_pkg.sv
ifu/ifu.sv
idu/idu.sv
exu/exu.sv
wbu/wbu.sv
hdl/core_top.sv
test/tb_clock.sv
test/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
